//--- compile.f
verilog/vc_test_pkg.sv
verilog/vc_test_source.sv
verilog/vc_test_delay.sv
verilog/vc_test_sink.sv
verilog/vc_test_harness.sv
verif/tb_vc_test_harness.sv

//--- run.sh
#!/usr/bin/env bash
# Build the stream rig testbench with Verilator, run it, look for the pass line

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert \
  -f compile.f \
  --top-module tb_vc_test_harness \
  --Mdir "$build_dir" -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$("./$build_dir/sim")
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

//--- verif/tb_vc_test_harness.sv
/*
 Self-checking testbench for the stream rig against a queue model.
 Random message lists come from a fixed seed.
*/
`default_nettype none

module tb_vc_test_harness;

  localparam int N_RUNS = 12;

  logic                  clk;
  logic                  reset;
  vc_test_pkg::delay_t   delay_amt;
  vc_test_pkg::idx_t     num_msgs;
  logic                  load_en;
  vc_test_pkg::idx_t     load_addr;
  vc_test_pkg::msg_t     load_src_msg;
  vc_test_pkg::msg_t     load_sink_msg;
  logic                  sink_val;
  logic                  sink_rdy;
  vc_test_pkg::msg_t     sink_msg;
  logic                  done;
  vc_test_pkg::err_cnt_t error_count;

  integer seed;
  int     errors;
  int     checks;
  int     limit_cycles;
  int     run_num [N_RUNS];
  int     run_dly [N_RUNS];
  int     run_k   [N_RUNS];

  // Model of the current run
  vc_test_pkg::msg_t src_q [$];
  vc_test_pkg::msg_t exp_q [$];
  int cur_delay;
  int rx_cnt;
  int pos;
  int last_pos;

  vc_test_harness i_dut
  (
    .clk           (clk),
    .reset         (reset),
    .delay_amt     (delay_amt),
    .num_msgs      (num_msgs),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_src_msg  (load_src_msg),
    .load_sink_msg (load_sink_msg),
    .sink_val      (sink_val),
    .sink_rdy      (sink_rdy),
    .sink_msg      (sink_msg),
    .done          (done),
    .error_count   (error_count)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // Uniform pick in 0 .. n-1
  function automatic int rand_below(input int n);
    int unsigned u;
    u = $unsigned($random(seed));
    return int'(u % n);
  endfunction

  // --------------------------------------------------------------------------
  // Monitor sampled mid-cycle where the channel is settled
  // --------------------------------------------------------------------------

  always @(negedge clk)
  begin
    if (reset)
    begin
      rx_cnt = 0;
      pos    = 0;
    end
    else
    begin
      if (sink_val && sink_rdy)
      begin
        if (rx_cnt < src_q.size())
        begin
          check_value("sink_msg", 32'(sink_msg), 32'(src_q[rx_cnt]));
        end
        else
        begin
          errors++;
          $display("Transfer beyond the %0d listed messages at %0t", src_q.size(), $time);
        end
        // First message after delay_amt idle cycles
        if (rx_cnt == 0)
        begin
          check_value("first_gap", 32'(pos), 32'(cur_delay));
        end
        // Later messages every delay_amt+1 cycles
        else
        begin
          check_value("transfer_gap", 32'(pos - last_pos), 32'(cur_delay + 1));
        end
        last_pos = pos;
        rx_cnt++;
      end
      pos++;
    end
  end

  // --------------------------------------------------------------------------
  // One run with its own lists, loaded under reset
  // --------------------------------------------------------------------------

  task automatic do_run(input int n, input int d, input int k);
    int i;
    int idx;
    int bad;
    int exp_err;
    int wait_cyc;
    @(posedge clk);
    #1;
    reset     = 1'b1;
    num_msgs  = vc_test_pkg::idx_t'(n);
    delay_amt = vc_test_pkg::delay_t'(d);
    cur_delay = d;
    src_q.delete();
    exp_q.delete();
    for (i = 0; i < n; i++)
    begin
      src_q.push_back(vc_test_pkg::msg_t'(rand_below(1 << vc_test_pkg::MSG_NBITS)));
      exp_q.push_back(src_q[i]);
    end
    // Corrupt k distinct expected entries
    bad = 0;
    while (bad < k)
    begin
      idx = rand_below(n);
      if (exp_q[idx] == src_q[idx])
      begin
        exp_q[idx] = exp_q[idx] ^
          vc_test_pkg::msg_t'(1 + rand_below((1 << vc_test_pkg::MSG_NBITS) - 1));
        bad++;
      end
    end
    for (i = 0; i < n; i++)
    begin
      load_en       = 1'b1;
      load_addr     = vc_test_pkg::idx_t'(i);
      load_src_msg  = src_q[i];
      load_sink_msg = exp_q[i];
      @(posedge clk);
      #1;
    end
    load_en = 1'b0;
    // Two more reset cycles with the reset state checked between them
    @(posedge clk);
    @(negedge clk);
    check_value("sink_val", 32'(sink_val), 32'h0);
    check_value("done", 32'(done), 32'h0);
    check_value("error_count", 32'(error_count), 32'h0);
    check_value("sink_rdy", 32'(sink_rdy), 32'h1);
    @(posedge clk);
    #1;
    reset = 1'b0;
    // Last transfer lands on negedge n*(d+1)-1 counted from zero
    // Done shows on the negedge after it
    wait_cyc = 0;
    while (!done)
    begin
      @(negedge clk);
      wait_cyc++;
    end
    @(negedge clk);
    exp_err = 0;
    for (i = 0; i < n; i++)
    begin
      if (exp_q[i] != src_q[i])
      begin
        exp_err++;
      end
    end
    check_value("transfer_count", 32'(rx_cnt), 32'(n));
    check_value("error_count", 32'(error_count), 32'(exp_err));
    check_value("done_cycle", 32'(wait_cyc), 32'(n * (d + 1) + 1));
    // Sink stops accepting once done
    check_value("sink_rdy", 32'(sink_rdy), 32'h0);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial
  begin
    int r;
    int total;
    clk           = 1'b0;
    reset         = 1'b1;
    delay_amt     = '0;
    num_msgs      = '0;
    load_en       = 1'b0;
    load_addr     = '0;
    load_src_msg  = '0;
    load_sink_msg = '0;
    seed          = 32'h4acfa9eb;
    errors        = 0;
    checks        = 0;
    limit_cycles  = 0;
    // Fixed delays with clean lists
    run_num[0] = 16;
    run_dly[0] = 0;
    run_num[1] = 16;
    run_dly[1] = 1;
    run_num[2] = 16;
    run_dly[2] = 2;
    run_num[3] = 16;
    run_dly[3] = 10;
    for (r = 0; r < 4; r++)
    begin
      run_k[r] = 0;
    end
    // Corrupted expected lists
    run_num[4] = 32;
    run_dly[4] = 1;
    run_k[4]   = 1 + rand_below(8);
    run_num[5] = 64;
    run_dly[5] = 0;
    run_k[5]   = 1 + rand_below(20);
    // Random clean runs
    for (r = 6; r < N_RUNS; r++)
    begin
      run_num[r] = 1 + rand_below(vc_test_pkg::MEM_DEPTH);
      run_dly[r] = rand_below(8);
      run_k[r]   = 0;
    end
    total = 0;
    for (r = 0; r < N_RUNS; r++)
    begin
      total += run_num[r] * (run_dly[r] + 1) + 100;
    end
    limit_cycles = total;
    for (r = 0; r < N_RUNS; r++)
    begin
      do_run(run_num[r], run_dly[r], run_k[r]);
    end
    repeat (2) @(posedge clk);
    $display("Errors: %0d, checks: %0d", errors, checks);
    if (errors == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog sized from the run list
  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: runs did not complete within %0d cycles", limit_cycles);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/vc_test_harness.sv
/*
 Source, delay stage and sink wired into one self-checking stream rig.
 Load both memories and set num_msgs and delay_amt while reset is high.
*/
`default_nettype none

module vc_test_harness
(
  input  logic                  clk,
  input  logic                  reset,
  input  vc_test_pkg::delay_t   delay_amt,
  input  vc_test_pkg::idx_t     num_msgs,
  input  logic                  load_en,
  input  vc_test_pkg::idx_t     load_addr,
  input  vc_test_pkg::msg_t     load_src_msg,
  input  vc_test_pkg::msg_t     load_sink_msg,
  output logic                  sink_val,
  output logic                  sink_rdy,
  output vc_test_pkg::msg_t     sink_msg,
  output logic                  done,
  output vc_test_pkg::err_cnt_t error_count
);

  // -------------------------------------------------------------------------
  // Source to delay channel
  // -------------------------------------------------------------------------

  logic              src_val;
  logic              src_rdy;
  vc_test_pkg::msg_t src_msg;
  logic              src_done;
  logic              sink_done;

  vc_test_source i_source
  (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_msg  (load_src_msg),
    .num_msgs  (num_msgs),
    .rdy       (src_rdy),
    .val       (src_val),
    .msg       (src_msg),
    .done      (src_done)
  );

  vc_test_delay i_delay
  (
    .clk       (clk),
    .reset     (reset),
    .delay_amt (delay_amt),
    .in_val    (src_val),
    .in_msg    (src_msg),
    .out_rdy   (sink_rdy),
    .in_rdy    (src_rdy),
    .out_val   (sink_val),
    .out_msg   (sink_msg)
  );

  // Delay to sink channel is visible at the top
  vc_test_sink i_sink
  (
    .clk         (clk),
    .reset       (reset),
    .load_en     (load_en),
    .load_addr   (load_addr),
    .load_msg    (load_sink_msg),
    .num_msgs    (num_msgs),
    .val         (sink_val),
    .msg         (sink_msg),
    .rdy         (sink_rdy),
    .done        (sink_done),
    .error_count (error_count)
  );

  // Run complete once everything is sent and checked
  assign done = src_done && sink_done;

endmodule

`default_nettype wire

//--- verilog/vc_test_sink.sv
/*
 Checks num_msgs received messages against a preloaded expected list.
 Load the memory only while reset is high; error_count saturates at 255.
*/
`default_nettype none

module vc_test_sink
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  load_en,
  input  vc_test_pkg::idx_t     load_addr,
  input  vc_test_pkg::msg_t     load_msg,
  input  vc_test_pkg::idx_t     num_msgs,
  input  logic                  val,
  input  vc_test_pkg::msg_t     msg,
  output logic                  rdy,
  output logic                  done,
  output vc_test_pkg::err_cnt_t error_count
);

  // -------------------------------------------------------------------------
  // Expected-message memory
  // -------------------------------------------------------------------------

  vc_test_pkg::msg_t mem [vc_test_pkg::MEM_DEPTH];

  always_ff @(posedge clk)
  begin
    if (load_en)
    begin
      mem[load_addr[vc_test_pkg::ADDR_NBITS-1:0]] <= load_msg;
    end
  end

  // -------------------------------------------------------------------------
  // Compare and count
  // -------------------------------------------------------------------------

  vc_test_pkg::idx_t rcv_q;
  vc_test_pkg::msg_t expected;
  logic              xfer;
  logic              mismatch;

  // Always ready until the run is complete
  assign rdy      = !done;
  assign xfer     = val && rdy;

  assign expected = mem[rcv_q[vc_test_pkg::ADDR_NBITS-1:0]];
  assign mismatch = (msg != expected);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rcv_q       <= '0;
      error_count <= '0;
      done        <= 1'b0;
    end
    else if (xfer)
    begin
      rcv_q <= rcv_q + vc_test_pkg::idx_t'(1);
      // Saturate rather than wrap
      if (mismatch && (error_count != vc_test_pkg::ERR_CNT_MAX))
      begin
        error_count <= error_count + vc_test_pkg::err_cnt_t'(1);
      end
      // Done on the edge of the last expected transfer
      if ((rcv_q + vc_test_pkg::idx_t'(1)) == num_msgs)
      begin
        done <= 1'b1;
      end
    end
  end

  // Upstream must run dry by the time the sink is done
  a_no_val_after_done: assert property (@(posedge clk) disable iff (reset)
    done |-> !val);

endmodule

`default_nettype wire

//--- verilog/vc_test_delay.sv
/*
 Inserts delay_amt idle cycles before each message on a val/rdy channel.
 delay_amt of zero makes the stage a plain combinational pass-through.
 delay_amt must be held steady while reset is low.
*/
`default_nettype none

module vc_test_delay
(
  input  logic                clk,
  input  logic                reset,
  input  vc_test_pkg::delay_t delay_amt,
  input  logic                in_val,
  input  vc_test_pkg::msg_t   in_msg,
  input  logic                out_rdy,
  output logic                in_rdy,
  output logic                out_val,
  output vc_test_pkg::msg_t   out_msg
);

  vc_test_pkg::delay_state_t state_q;
  vc_test_pkg::delay_t       cnt_q;
  logic                      passthru;
  logic                      xfer;

  // -------------------------------------------------------------------------
  // Channel gating
  // -------------------------------------------------------------------------

  // Open in PASS, or always open with no delay set
  assign passthru = (delay_amt == '0) || (state_q == vc_test_pkg::PASS);

  assign out_val  = passthru && in_val;
  assign in_rdy   = passthru && out_rdy;

  // Payload never stored here
  assign out_msg  = in_msg;

  assign xfer     = out_val && out_rdy;

  // -------------------------------------------------------------------------
  // State machine and idle counter
  // -------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q <= vc_test_pkg::WAIT;
      cnt_q   <= delay_amt;
    end
    else
    begin
      case (state_q)
        vc_test_pkg::WAIT:
        begin
          // Counts regardless of in_val; last idle cycle opens the gate
          if (cnt_q <= vc_test_pkg::delay_t'(1))
          begin
            state_q <= vc_test_pkg::PASS;
            cnt_q   <= '0;
          end
          else
          begin
            cnt_q <= cnt_q - vc_test_pkg::delay_t'(1);
          end
        end
        vc_test_pkg::PASS:
        begin
          // Back-pressure holds here without counting
          if (xfer)
          begin
            state_q <= vc_test_pkg::WAIT;
            cnt_q   <= delay_amt;
          end
        end
        default:
        begin
          state_q <= vc_test_pkg::WAIT;
          cnt_q   <= delay_amt;
        end
      endcase
    end
  end

  // Never invents a message the source did not offer
  a_val_from_source: assert property (@(posedge clk) disable iff (reset)
    out_val |-> in_val);

  // Idle gap restarts only after a message has gone through
  a_no_early_reload: assert property (@(posedge clk) disable iff (reset)
    ((state_q == vc_test_pkg::PASS) && !xfer)
      |=> ((state_q == vc_test_pkg::PASS) && $stable(cnt_q)));

endmodule

`default_nettype wire

//--- verilog/vc_test_source.sv
/*
 Plays num_msgs preloaded messages in order over a val/rdy channel.
 Load the memory and change num_msgs only while reset is high.
*/
`default_nettype none

module vc_test_source
(
  input  logic              clk,
  input  logic              reset,
  input  logic              load_en,
  input  vc_test_pkg::idx_t load_addr,
  input  vc_test_pkg::msg_t load_msg,
  input  vc_test_pkg::idx_t num_msgs,
  input  logic              rdy,
  output logic              val,
  output vc_test_pkg::msg_t msg,
  output logic              done
);

  // -------------------------------------------------------------------------
  // Message memory
  // -------------------------------------------------------------------------

  vc_test_pkg::msg_t mem [vc_test_pkg::MEM_DEPTH];

  // Written from the load port
  always_ff @(posedge clk)
  begin
    if (load_en)
    begin
      mem[load_addr[vc_test_pkg::ADDR_NBITS-1:0]] <= load_msg;
    end
  end

  // -------------------------------------------------------------------------
  // In-order player
  // -------------------------------------------------------------------------

  vc_test_pkg::idx_t rd_idx;
  logic              more;
  logic              xfer;

  // Messages left to send
  assign more = (rd_idx < num_msgs);

  // Channel stays idle while the rig is held in reset
  assign val  = more && !reset;
  assign xfer = val && rdy;

  // Entry at the read index, held until it is taken
  assign msg  = mem[rd_idx[vc_test_pkg::ADDR_NBITS-1:0]];
  assign done = !more;

  // Advance one entry per transfer
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_idx <= '0;
    end
    else if (xfer)
    begin
      rd_idx <= rd_idx + vc_test_pkg::idx_t'(1);
    end
  end

  // A stalled message must not change under the consumer
  a_msg_stable: assert property (@(posedge clk) disable iff (reset)
    (val && !rdy) |=> (val && $stable(msg)));

endmodule

`default_nettype wire

//--- verilog/vc_test_pkg.sv
/*
 Shared widths and types for the stream test rig.
 Memories hold MEM_DEPTH entries, so num_msgs must not exceed MEM_DEPTH.
*/
`default_nettype none

package vc_test_pkg;

  // Sizes
  localparam int MSG_NBITS   = 8;
  localparam int MEM_DEPTH   = 64;
  localparam int ADDR_NBITS  = $clog2(MEM_DEPTH);
  // One extra bit so a count can reach MEM_DEPTH
  localparam int IDX_NBITS   = ADDR_NBITS + 1;
  localparam int DELAY_NBITS = 32;
  localparam int ERR_NBITS   = 8;

  typedef logic [MSG_NBITS-1:0]   msg_t;
  typedef logic [IDX_NBITS-1:0]   idx_t;
  typedef logic [DELAY_NBITS-1:0] delay_t;
  typedef logic [ERR_NBITS-1:0]   err_cnt_t;

  // Saturation point of the mismatch counter
  localparam err_cnt_t ERR_CNT_MAX = '1;

  // Delay stage states
  typedef enum logic {
    WAIT,
    PASS
  } delay_state_t;

endpackage

`default_nettype wire
